/* pit_pkg.sv */
package pit_pkg;

	// ========================================
	// sizes
	// ========================================

	// number of timer channels
	localparam int PIT_NCHAN = 4;
	// data bus and counter width
	localparam int PIT_DW = 32;
	// byte address width, bits 5:4 pick the channel and bits 3:2 the register
	localparam int PIT_AW = 6;
	// width of the channel field in the address
	localparam int PIT_CSEL_W = $clog2(PIT_NCHAN);
	// one control byte per channel in the control word
	localparam int PIT_CTRL_W = 8;
	// meaningful bits in a control byte
	localparam int PIT_CTRL_BITS = 5;

	// data and count word
	typedef logic [PIT_DW-1:0] pit_word_t;

	// ========================================
	// register map
	// ========================================

	// byte offsets inside a channel's 16-byte block
	// count is read only, ctrl is shared by all channels
	typedef enum logic [3:0] {
		PIT_REG_COUNT = 4'h0,
		PIT_REG_MAX   = 4'h4,
		PIT_REG_ONT   = 4'h8,
		PIT_REG_CTRL  = 4'hC
	} pit_reg_e;

	// ========================================
	// control byte
	// ========================================

	// bit 0 load, self clearing
	// bit 1 enable counting
	// bit 2 reload from max count at zero
	// bit 3 count external clock edges
	// bit 4 count only while gate is high
	typedef struct packed {
		logic [PIT_CTRL_W-PIT_CTRL_BITS-1:0] unused;
		logic                                gate_en;
		logic                                ext_clk;
		logic                                auto_rld;
		logic                                enable;
		logic                                load;
	} pit_ctrl_t;

	// control byte after reset, auto-reload on and everything else off
	localparam pit_ctrl_t PIT_CTRL_RST = '{
		unused:   '0,
		gate_en:  1'b0,
		ext_clk:  1'b0,
		auto_rld: 1'b1,
		enable:   1'b0,
		load:     1'b0
	};

endpackage

/* pit_chan_if.sv */
`timescale 1ns/100ps

interface pit_chan_if;
	import pit_pkg::*;

	// register stage to channel
	pit_word_t max_cnt;
	pit_word_t on_time;
	// single-cycle strobe, ctrl_wdata is valid with it
	logic      ctrl_wr;
	pit_ctrl_t ctrl_wdata;

	// channel back to register stage
	pit_word_t count;
	pit_ctrl_t ctrl_rdata;
	// output level, also goes to the top-level out_o
	logic      out;

	// register side
	modport regs (
		output max_cnt,
		output on_time,
		output ctrl_wr,
		output ctrl_wdata,
		input  count,
		input  ctrl_rdata,
		input  out
	);

	// counting channel side
	modport chan (
		input  max_cnt,
		input  on_time,
		input  ctrl_wr,
		input  ctrl_wdata,
		output count,
		output ctrl_rdata,
		output out
	);

endinterface

/* pit_input_sync.sv */
`timescale 1ns/100ps

module pit_input_sync (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic [pit_pkg::PIT_NCHAN-1:0] ext_clk_i,
	input  logic [pit_pkg::PIT_NCHAN-1:0] gate_i,
	output logic [pit_pkg::PIT_NCHAN-1:0] ext_tick_o,
	output logic [pit_pkg::PIT_NCHAN-1:0] gate_s_o
);
	import pit_pkg::*;

	// external clock synchronizer stages
	logic [PIT_NCHAN-1:0] ext_ff1_q;
	logic [PIT_NCHAN-1:0] ext_ff2_q;
	// previous synchronized clock for edge detect
	logic [PIT_NCHAN-1:0] ext_prev_q;
	// registered rising-edge pulse
	logic [PIT_NCHAN-1:0] tick_q;

	// gate synchronizer stages
	logic [PIT_NCHAN-1:0] gate_ff1_q;
	logic [PIT_NCHAN-1:0] gate_ff2_q;

	// ========================================
	// two-flop synchronizers
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ext_ff1_q  <= '0;
			ext_ff2_q  <= '0;
			gate_ff1_q <= '0;
			gate_ff2_q <= '0;
		end else begin
			ext_ff1_q  <= ext_clk_i;
			ext_ff2_q  <= ext_ff1_q;
			gate_ff1_q <= gate_i;
			gate_ff2_q <= gate_ff1_q;
		end
	end

	// ========================================
	// rising edge detect
	// ========================================

	// edge on the synchronized clock becomes a one-cycle tick
	// input edge to tick is three clocks in total
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ext_prev_q <= '0;
			tick_q     <= '0;
		end else begin
			ext_prev_q <= ext_ff2_q;
			tick_q     <= ext_ff2_q & ~ext_prev_q;
		end
	end

	assign ext_tick_o = tick_q;
	// gate level is used straight from the second flop
	assign gate_s_o   = gate_ff2_q;

endmodule

/* pit_regs.sv */
`timescale 1ns/100ps

module pit_regs (
	input  logic                          clk_i,
	input  logic                          rst_i,
	input  logic                          cs_i,
	input  logic                          cyc_i,
	input  logic                          stb_i,
	input  logic                          we_i,
	input  logic [pit_pkg::PIT_NCHAN-1:0] sel_i,
	input  logic [pit_pkg::PIT_AW-1:0]    adr_i,
	input  pit_pkg::pit_word_t            dat_i,
	output pit_pkg::pit_word_t            dat_o,
	output logic                          ack_o,
	pit_chan_if.regs                      chan [0:pit_pkg::PIT_NCHAN-1]
);
	import pit_pkg::*;

	// bus qualifiers
	logic                  bus_cs;
	logic                  wr_acc;
	logic                  rd_acc;
	logic                  rd_rdy_q;
	// address fields
	logic [PIT_CSEL_W-1:0] csel;
	pit_reg_e              reg_sel;

	// per-channel storage and status taps
	pit_word_t             max_q  [PIT_NCHAN];
	pit_word_t             ont_q  [PIT_NCHAN];
	pit_word_t             cnt_arr [PIT_NCHAN];
	// all four control bytes as one read word
	pit_word_t             ctrl_word;
	pit_word_t             rd_word;

	// ========================================
	// bus decode
	// ========================================

	assign bus_cs  = cyc_i & stb_i & cs_i;
	assign wr_acc  = bus_cs & we_i;
	assign rd_acc  = bus_cs & ~we_i;
	assign csel    = adr_i[PIT_AW-1 -: PIT_CSEL_W];
	// word offset inside the channel block, low two address bits ignored
	assign reg_sel = pit_reg_e'({adr_i[3:2], 2'b00});

	// writes ack at once, reads after the data register is loaded
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_rdy_q <= 1'b0;
		end else begin
			rd_rdy_q <= rd_acc;
		end
	end

	assign ack_o = bus_cs & (we_i | rd_rdy_q);

	// ========================================
	// max count and on-time
	// ========================================

	always_ff @(posedge clk_i) begin
		for (int i = 0; i < PIT_NCHAN; i++) begin
			if (wr_acc && int'(csel) == i) begin
				if (reg_sel == PIT_REG_MAX) begin
					max_q[i] <= dat_i;
				end
				if (reg_sel == PIT_REG_ONT) begin
					ont_q[i] <= dat_i;
				end
			end
		end
	end

	// ========================================
	// channel connections
	// ========================================

	for (genvar i = 0; i < PIT_NCHAN; i++) begin : g_chan
		pit_ctrl_t rd_byte;

		assign chan[i].max_cnt = max_q[i];
		assign chan[i].on_time = ont_q[i];

		// control write goes to every channel, byte lane i picks channel i
		// channel field of the address plays no part here
		assign chan[i].ctrl_wr    = wr_acc & (reg_sel == PIT_REG_CTRL) & sel_i[i];
		// reserved bits are written as zero
		assign chan[i].ctrl_wdata = pit_ctrl_t'({
			{(PIT_CTRL_W-PIT_CTRL_BITS){1'b0}},
			dat_i[PIT_CTRL_W*i +: PIT_CTRL_BITS]
		});

		assign cnt_arr[i] = chan[i].count;

		// load is a strobe and always reads back as zero
		always_comb begin
			rd_byte      = chan[i].ctrl_rdata;
			rd_byte.load = 1'b0;
		end

		assign ctrl_word[PIT_CTRL_W*i +: PIT_CTRL_W] = rd_byte;
	end

	// ========================================
	// read data
	// ========================================

	always_comb begin
		case (reg_sel)
			PIT_REG_COUNT: rd_word = cnt_arr[csel];
			PIT_REG_MAX:   rd_word = max_q[csel];
			PIT_REG_ONT:   rd_word = ont_q[csel];
			PIT_REG_CTRL:  rd_word = ctrl_word;
			default:       rd_word = '0;
		endcase
	end

	// dat_o holds the addressed word during a read and is zero otherwise
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			dat_o <= '0;
		end else if (rd_acc) begin
			dat_o <= rd_word;
		end else begin
			dat_o <= '0;
		end
	end

endmodule

/* pit_channel.sv */
`timescale 1ns/100ps

module pit_channel (
	input  logic     clk_i,
	input  logic     rst_i,
	input  logic     ext_tick_i,
	input  logic     gate_i,
	pit_chan_if.chan bus
);
	import pit_pkg::*;

	pit_ctrl_t ctrl_q;
	pit_word_t count_q;
	logic      out_q;

	// tick qualification
	logic      tick_src;
	logic      gate_ok;
	logic      tick_ok;
	// compare results on the old count
	logic      at_ont;
	logic      at_zero;
	// count hits zero without the on-time match taking priority
	logic      zero_hit;

	// ========================================
	// tick qualification
	// ========================================

	// internal clock ticks every cycle, external clock on synced edges only
	assign tick_src = ctrl_q.ext_clk ? ext_tick_i : 1'b1;
	assign gate_ok  = ~ctrl_q.gate_en | gate_i;
	// a pending load wins over counting
	assign tick_ok  = ~ctrl_q.load & ctrl_q.enable & tick_src & gate_ok;

	assign at_ont   = (count_q == bus.on_time);
	assign at_zero  = (count_q == '0);
	assign zero_hit = tick_ok & ~at_ont & at_zero;

	// ========================================
	// control register
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ctrl_q <= PIT_CTRL_RST;
		end else if (bus.ctrl_wr) begin
			ctrl_q <= bus.ctrl_wdata;
		end else begin
			// load lasts exactly one cycle
			ctrl_q.load <= 1'b0;
			// one-shot mode stops itself at zero
			if (zero_hit && !ctrl_q.auto_rld) begin
				ctrl_q.enable <= 1'b0;
			end
		end
	end

	// ========================================
	// down counter and output
	// ========================================

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			count_q <= '0;
		end else if (ctrl_q.load) begin
			count_q <= bus.max_cnt;
		end else if (tick_ok) begin
			if (zero_hit && ctrl_q.auto_rld) begin
				count_q <= bus.max_cnt;
			end else begin
				// a stopped one-shot is left at the wrapped value
				count_q <= count_q - 1'b1;
			end
		end
	end

	// high from the on-time match until the count reaches zero
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			out_q <= 1'b0;
		end else if (tick_ok) begin
			if (at_ont) begin
				out_q <= 1'b1;
			end else if (at_zero) begin
				out_q <= 1'b0;
			end
		end
	end

	assign bus.count      = count_q;
	assign bus.ctrl_rdata = ctrl_q;
	assign bus.out        = out_q;

endmodule

/* pit_top.sv */
`timescale 1ns/100ps

module pit_top (
	input  logic                          clk_i,
	input  logic                          rst_i,
	// bus slave port
	input  logic                          cs_i,
	input  logic                          cyc_i,
	input  logic                          stb_i,
	input  logic                          we_i,
	input  logic [pit_pkg::PIT_NCHAN-1:0] sel_i,
	input  logic [pit_pkg::PIT_AW-1:0]    adr_i,
	input  pit_pkg::pit_word_t            dat_i,
	output pit_pkg::pit_word_t            dat_o,
	output logic                          ack_o,
	// timer pins, one bit per channel
	input  logic [pit_pkg::PIT_NCHAN-1:0] ext_clk_i,
	input  logic [pit_pkg::PIT_NCHAN-1:0] gate_i,
	output logic [pit_pkg::PIT_NCHAN-1:0] out_o
);
	import pit_pkg::*;

	// synchronized pin state
	logic [PIT_NCHAN-1:0] ext_tick;
	logic [PIT_NCHAN-1:0] gate_s;

	// one register-to-channel link per channel
	pit_chan_if chan_bus [0:PIT_NCHAN-1] ();

	// ========================================
	// stage 1, pin synchronizer
	// ========================================

	pit_input_sync i_sync (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.ext_clk_i  (ext_clk_i),
		.gate_i     (gate_i),
		.ext_tick_o (ext_tick),
		.gate_s_o   (gate_s)
	);

	// stage 2, bus and registers
	pit_regs i_regs (
		.clk_i (clk_i),
		.rst_i (rst_i),
		.cs_i  (cs_i),
		.cyc_i (cyc_i),
		.stb_i (stb_i),
		.we_i  (we_i),
		.sel_i (sel_i),
		.adr_i (adr_i),
		.dat_i (dat_i),
		.dat_o (dat_o),
		.ack_o (ack_o),
		.chan  (chan_bus)
	);

	// stage 3, counting channels
	for (genvar g = 0; g < PIT_NCHAN; g++) begin : g_chan
		pit_channel i_chan (
			.clk_i      (clk_i),
			.rst_i      (rst_i),
			.ext_tick_i (ext_tick[g]),
			.gate_i     (gate_s[g]),
			.bus        (chan_bus[g])
		);

		assign out_o[g] = chan_bus[g].out;
	end

endmodule

/* pit_props.sv */
`timescale 1ns/100ps

module pit_props (
	input logic                          clk_i,
	input logic                          rst_i,
	input logic                          cs_i,
	input logic                          cyc_i,
	input logic                          stb_i,
	input logic                          we_i,
	input logic                          ack_i,
	input logic [pit_pkg::PIT_NCHAN-1:0] out_i
);
	// active bus accesses
	logic wr_acc;
	logic rd_acc;

	assign wr_acc = cyc_i & stb_i & cs_i & we_i;
	assign rd_acc = cyc_i & stb_i & cs_i & ~we_i;

	// write ack comes in the same cycle
	a_wr_ack: assert property (@(posedge clk_i) disable iff (rst_i) wr_acc |-> ack_i)
		else $error("write access was not acknowledged in its first cycle");

	// first cycle of a read has no ack yet
	a_rd_wait: assert property (@(posedge clk_i) disable iff (rst_i)
		(rd_acc && !$past(rd_acc)) |-> !ack_i)
		else $error("read acknowledged before the data was registered");

	// from the second cycle on the read is acked
	a_rd_ack: assert property (@(posedge clk_i) disable iff (rst_i)
		(rd_acc && $past(rd_acc)) |-> ack_i)
		else $error("read access not acknowledged on the cycle after it began");

	// bus and timer pins are quiet right after reset
	a_rst_quiet: assert property (@(posedge clk_i) $fell(rst_i) |-> (!ack_i && out_i == '0))
		else $error("ack or timer outputs not low after reset");

endmodule

bind pit_top pit_props i_props (
	.clk_i (clk_i),
	.rst_i (rst_i),
	.cs_i  (cs_i),
	.cyc_i (cyc_i),
	.stb_i (stb_i),
	.we_i  (we_i),
	.ack_i (ack_o),
	.out_i (out_o)
);

/* tb_pit_top.sv */
`timescale 1ns/100ps

module tb_pit_top;
	import pit_pkg::*;

	localparam int CLK_PERIOD  = 20;
	// reset, readback, sync start, then 24 slow edges at about 21 cycles each
	localparam int TEST_CYCLES = 800;
	localparam pit_word_t SYNC_MAX = 32'd500;
	// idle cycles between the synchronized start and stop writes
	localparam int SYNC_RUN = 20;
	// one decrement per cycle after the load cycle, up to and including the stop edge
	localparam pit_word_t SYNC_EXP = SYNC_MAX - pit_word_t'(SYNC_RUN + 1);

	// channel state after one qualified tick
	typedef struct packed {
		pit_word_t count;
		logic      out;
		logic      stop;
	} tick_res_t;

	logic                 clk_i;
	logic                 rst_i;
	logic                 cs_i;
	logic                 cyc_i;
	logic                 stb_i;
	logic                 we_i;
	logic [PIT_NCHAN-1:0] sel_i;
	logic [PIT_AW-1:0]    adr_i;
	pit_word_t            dat_i;
	pit_word_t            dat_o;
	logic                 ack_o;
	logic [PIT_NCHAN-1:0] ext_clk_i;
	logic [PIT_NCHAN-1:0] gate_i;
	logic [PIT_NCHAN-1:0] out_o;

	int                   seed;
	// model of each channel
	pit_word_t            m_count [PIT_NCHAN];
	pit_word_t            m_max   [PIT_NCHAN];
	pit_word_t            m_ont   [PIT_NCHAN];
	logic                 m_rld   [PIT_NCHAN];
	logic                 m_run   [PIT_NCHAN];
	logic [PIT_NCHAN-1:0] m_out;

	pit_top i_dut (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.cs_i      (cs_i),
		.cyc_i     (cyc_i),
		.stb_i     (stb_i),
		.we_i      (we_i),
		.sel_i     (sel_i),
		.adr_i     (adr_i),
		.dat_i     (dat_i),
		.dat_o     (dat_o),
		.ack_o     (ack_o),
		.ext_clk_i (ext_clk_i),
		.gate_i    (gate_i),
		.out_o     (out_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD/2) clk_i = ~clk_i;
	end

	// run length bound, twice the planned cycles
	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("timeout, tests did not finish within %0d cycles", 2 * TEST_CYCLES);
		$display("Result: FAILED");
		$fatal(1, "watchdog expired");
	end

	// ========================================
	// reference model and compare tasks
	// ========================================

	// on-time match sets out, zero clears it and reloads or stops
	function automatic tick_res_t model_tick(pit_word_t count, pit_word_t max_cnt,
		pit_word_t on_time, logic auto_rld, logic out_prev);
		tick_res_t res;
		res.count = count - 32'd1;
		res.out   = out_prev;
		res.stop  = 1'b0;
		if (count == on_time) begin
			res.out = 1'b1;
		end else if (count == '0) begin
			res.out = 1'b0;
			if (auto_rld) begin
				res.count = max_cnt;
			end else begin
				res.stop = 1'b1;
			end
		end
		return res;
	endfunction

	task automatic stop_with_error(string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(string name, pit_word_t got, pit_word_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("ERROR at %0t: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_out(string name, logic [PIT_NCHAN-1:0] got,
		logic [PIT_NCHAN-1:0] exp);
		if (got !== exp) begin
			stop_with_error($sformatf("ERROR at %0t: %s is %b, expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic check_ctrl(string name, pit_ctrl_t got, pit_ctrl_t exp);
		if (got !== exp) begin
			stop_with_error($sformatf("ERROR at %0t: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	// ========================================
	// bus access
	// ========================================

	// byte address of a register in a channel block
	function automatic logic [PIT_AW-1:0] reg_addr(int ch, pit_reg_e r);
		return PIT_AW'(ch * 16 + int'(r));
	endfunction

	task automatic bus_write(logic [PIT_AW-1:0] adr, pit_word_t data,
		logic [PIT_NCHAN-1:0] sel);
		@(negedge clk_i);
		{cyc_i, stb_i, cs_i, we_i} = 4'b1111;
		adr_i = adr;
		dat_i = data;
		sel_i = sel;
		// write lands on the edge inside this loop
		do begin
			@(negedge clk_i);
		end while (!ack_o);
		{cyc_i, stb_i, cs_i, we_i} = 4'b0000;
	endtask

	task automatic bus_read(logic [PIT_AW-1:0] adr, output pit_word_t data);
		@(negedge clk_i);
		{cyc_i, stb_i, cs_i, we_i} = 4'b1110;
		adr_i = adr;
		// dat_o is valid while ack is up
		do begin
			@(negedge clk_i);
		end while (!ack_o);
		data = dat_o;
		{cyc_i, stb_i, cs_i, we_i} = 4'b0000;
	endtask

	// control byte with load set
	function automatic pit_ctrl_t make_ctrl(logic gate_en, logic ext_clk, logic auto_rld);
		return '{unused: '0, gate_en: gate_en, ext_clk: ext_clk, auto_rld: auto_rld,
			enable: 1'b1, load: 1'b1};
	endfunction

	// program one channel and start it through its own byte lane
	task automatic setup_channel(int ch, pit_word_t max_cnt, pit_word_t on_time,
		pit_ctrl_t ctrl);
		bus_write(reg_addr(ch, PIT_REG_MAX), max_cnt, '1);
		bus_write(reg_addr(ch, PIT_REG_ONT), on_time, '1);
		bus_write(reg_addr(ch, PIT_REG_CTRL), pit_word_t'(ctrl) << (8 * ch), 4'b0001 << ch);
		m_max[ch]   = max_cnt;
		m_ont[ch]   = on_time;
		m_rld[ch]   = ctrl.auto_rld;
		m_count[ch] = max_cnt;
		m_run[ch]   = ctrl.enable;
	endtask

	// one slow external clock period, 8 cycles high and 8 low
	task automatic ext_edge(int ch, logic gated_off);
		tick_res_t res;
		pit_word_t rd;
		@(negedge clk_i);
		ext_clk_i[ch] = 1'b1;
		repeat (8) @(negedge clk_i);
		ext_clk_i[ch] = 1'b0;
		repeat (8) @(negedge clk_i);
		if (m_run[ch] && !gated_off) begin
			res = model_tick(m_count[ch], m_max[ch], m_ont[ch], m_rld[ch], m_out[ch]);
			m_count[ch] = res.count;
			m_out[ch]   = res.out;
			m_run[ch]   = ~res.stop;
		end
		bus_read(reg_addr(ch, PIT_REG_COUNT), rd);
		check_word($sformatf("count[%0d]", ch), rd, m_count[ch]);
		check_out("out_o", out_o, m_out);
	endtask

	// ========================================
	// stimulus and checking
	// ========================================

	initial begin : check_proc
		pit_word_t rd;
		pit_word_t cword;
		pit_word_t wval;
		pit_ctrl_t exp_ctrl;

		seed = 63;
		rst_i = 1'b1;
		{cyc_i, stb_i, cs_i, we_i} = 4'b0000;
		sel_i = '0;
		adr_i = '0;
		dat_i = '0;
		ext_clk_i = '0;
		gate_i = '0;
		m_out = '0;
		for (int ch = 0; ch < PIT_NCHAN; ch++) begin
			m_run[ch] = 1'b0;
		end
		repeat (10) @(negedge clk_i);
		rst_i = 1'b0;

		// register readback, control bytes start at the reset value
		bus_read(reg_addr(0, PIT_REG_CTRL), rd);
		for (int ch = 0; ch < PIT_NCHAN; ch++) begin
			check_ctrl($sformatf("ctrl[%0d]", ch), pit_ctrl_t'(rd[8*ch +: 8]), PIT_CTRL_RST);
		end
		for (int ch = 0; ch < PIT_NCHAN; ch++) begin
			wval = $random(seed);
			bus_write(reg_addr(ch, PIT_REG_MAX), wval, '1);
			bus_read(reg_addr(ch, PIT_REG_MAX), rd);
			check_word($sformatf("max[%0d]", ch), rd, wval);
			wval = $random(seed);
			bus_write(reg_addr(ch, PIT_REG_ONT), wval, '1);
			bus_read(reg_addr(ch, PIT_REG_ONT), rd);
			check_word($sformatf("ontime[%0d]", ch), rd, wval);
		end
		// enable kept clear so nothing counts yet
		cword = $random(seed) & 32'h1D1D_1D1D;
		bus_write(reg_addr(2, PIT_REG_CTRL), cword, '1);
		bus_read(reg_addr(1, PIT_REG_CTRL), rd);
		for (int ch = 0; ch < PIT_NCHAN; ch++) begin
			exp_ctrl = pit_ctrl_t'(cword[8*ch +: 8]);
			exp_ctrl.load = 1'b0;
			check_ctrl($sformatf("ctrl[%0d]", ch), pit_ctrl_t'(rd[8*ch +: 8]), exp_ctrl);
		end

		// all four started by one write, stopped by another
		for (int ch = 0; ch < PIT_NCHAN; ch++) begin
			bus_write(reg_addr(ch, PIT_REG_MAX), SYNC_MAX, '1);
			bus_write(reg_addr(ch, PIT_REG_ONT), '0, '1);
		end
		bus_write(reg_addr(0, PIT_REG_CTRL), 32'h0707_0707, '1);
		repeat (SYNC_RUN) @(negedge clk_i);
		bus_write(reg_addr(0, PIT_REG_CTRL), 32'h0404_0404, '1);
		// every channel stopped on the same count
		for (int ch = 0; ch < PIT_NCHAN; ch++) begin
			bus_read(reg_addr(ch, PIT_REG_COUNT), rd);
			check_word($sformatf("count[%0d]", ch), rd, SYNC_EXP);
		end
		// load with enable clear puts max count back
		bus_write(reg_addr(0, PIT_REG_CTRL), 32'h0505_0505, '1);
		for (int ch = 0; ch < PIT_NCHAN; ch++) begin
			bus_read(reg_addr(ch, PIT_REG_COUNT), rd);
			check_word($sformatf("count[%0d]", ch), rd, SYNC_MAX);
		end
		check_out("out_o", out_o, m_out);

		// external clock with auto-reload, runs through zero once
		setup_channel(1, 32'd5, 32'd3, make_ctrl(1'b0, 1'b1, 1'b1));
		repeat (8) ext_edge(1, 1'b0);

		// one-shot stops at zero and clears its enable
		setup_channel(2, 32'd3, 32'd1, make_ctrl(1'b0, 1'b1, 1'b0));
		repeat (4) ext_edge(2, 1'b0);
		bus_read(reg_addr(2, PIT_REG_CTRL), rd);
		exp_ctrl = '{unused: '0, gate_en: 1'b0, ext_clk: 1'b1, auto_rld: 1'b0,
			enable: 1'b0, load: 1'b0};
		check_ctrl("ctrl[2]", pit_ctrl_t'(rd[23:16]), exp_ctrl);
		repeat (2) ext_edge(2, 1'b0);

		// auto-reload returns to max count after the zero edge
		setup_channel(3, 32'd2, 32'd1, make_ctrl(1'b0, 1'b1, 1'b1));
		repeat (3) ext_edge(3, 1'b0);
		bus_read(reg_addr(3, PIT_REG_COUNT), rd);
		check_word("count[3]", rd, 32'd2);

		// gate low blocks edges, then raised and given time to sync
		setup_channel(0, 32'd4, 32'd2, make_ctrl(1'b1, 1'b1, 1'b1));
		repeat (3) ext_edge(0, 1'b1);
		@(negedge clk_i);
		gate_i[0] = 1'b1;
		repeat (4) @(negedge clk_i);
		repeat (4) ext_edge(0, 1'b0);

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* pit_top.f */
pit_pkg.sv
pit_chan_if.sv
pit_input_sync.sv
pit_regs.sv
pit_channel.sv
pit_top.sv
pit_props.sv
tb_pit_top.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then judge the run from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_pit_top -f pit_top.f \
	&& ./obj_dir/Vtb_pit_top > sim.log 2>&1 \
	|| echo "Result: FAILED" >> sim.log
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1 || exit 0
